/* filelist.f */
hw/soc_pkg.sv
hw/disp_pkg.sv
hw/seg_scan_if.sv
hw/board_status_regs.sv
hw/panel_value_select.sv
hw/seg_scan.sv
hw/seg_drive.sv
hw/rgb_phase_gen.sv
hw/rgb_pwm_channel.sv
hw/priv_led_select.sv
hw/status_panel_top.sv
sim/tb_status_panel.sv

/* hw/board_status_regs.sv */
// Board status registers
// Heartbeat divider, the loading flag for the scrolling banner
// and the 16-bit LED status word

`timescale 1ns/1ps

module board_status_regs #(
    parameter int HEARTBEAT_HALF = 32000000
) (
    input  logic        CORE_CLK,
    input  logic        CORE_RST_X,
    input  logic        init_done,
    input  logic        init_start,
    input  logic        data_we,
    input  logic        busy,
    output logic        loading,
    output logic [15:0] led
);

    localparam int HB_W = $clog2(HEARTBEAT_HALF + 1);

    logic [HB_W-1:0] hb_cnt;
    logic            heartbeat;

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            hb_cnt    <= '0;
            heartbeat <= 1'b0;
            loading   <= 1'b0;
        end else begin
            if (hb_cnt == HB_W'(HEARTBEAT_HALF - 1)) begin
                hb_cnt    <= '0;
                heartbeat <= ~heartbeat;  // Toggle on wrap
            end else begin
                hb_cnt <= hb_cnt + 1'b1;
            end
            // Image load runs from init_start until init_done
            if (!loading && init_start && !init_done)
                loading <= 1'b1;
            else if (init_done)
                loading <= 1'b0;
        end
    end

    assign led = {12'd0, busy, data_we, init_done, heartbeat};

endmodule

/* hw/disp_pkg.sv */
// Display constants for the status panel
// Seven-segment glyph tables (active high, bit 7 is the dot),
// display modes and the widths of the RGB counters

package disp_pkg;

    localparam int N_DIGITS   = 8;
    localparam int PHASE_BITS = 12;  // PWM period is 2**PHASE_BITS cycles
    localparam int BLINK_BITS = 4;   // Privilege blink once per 16 cycles

    typedef logic [7:0] glyph_t;

    typedef enum logic [1:0] {
        DISP_INIT,
        DISP_LOAD,
        DISP_VALUE
    } disp_mode_e;

    // Hex digits 0 to F
    localparam glyph_t hex_glyph [16] = '{
        8'h7e, 8'h30, 8'h6d, 8'h79,
        8'h33, 8'h5b, 8'h5f, 8'h70,
        8'h7f, 8'h7b, 8'h77, 8'h1f,
        8'h4e, 8'h3d, 8'h4f, 8'h47
    };

    // Power-up banner, digit 0 first
    localparam glyph_t init_glyph [N_DIGITS] = '{
        8'h0d, 8'h1d, 8'h05, 8'h67,
        8'h17, 8'h0d, 8'h05, 8'h77
    };

    // Scrolling banner text
    localparam glyph_t load_glyph [16] = '{
        8'h00, 8'h00, 8'h00, 8'h00,
        8'h00, 8'h00, 8'h00, 8'h0e,  // blanks, then L
        8'h1d, 8'h7d, 8'h3d, 8'h10,  // o a d i
        8'h15, 8'hfb, 8'h80, 8'h80   // n g, trailing dots
    };

endpackage

/* hw/panel_value_select.sv */
// Panel value selector
// Keeps the last two keyboard and mouse bytes and registers the
// value picked by the push buttons for the hex view

`timescale 1ns/1ps

module panel_value_select (
    input  logic               CORE_CLK,
    input  logic               CORE_RST_X,
    input  logic               kbd_we,
    input  logic [7:0]         kbd_data,
    input  logic               mouse_we,
    input  logic [7:0]         mouse_data,
    input  logic               btn_up,
    input  logic               btn_down,
    input  logic               btn_left,
    input  logic               btn_right,
    input  logic               btn_center,
    input  soc_pkg::word_t     pc,
    input  soc_pkg::word_t     ir,
    output soc_pkg::word_t     value
);

    soc_pkg::word_t hist;  // {mouse prev, mouse last, kbd prev, kbd last}

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            hist  <= '0;
            value <= '0;
        end else begin
            if (kbd_we) begin
                hist[7:0]  <= kbd_data;
                hist[15:8] <= hist[7:0];
            end
            if (mouse_we) begin
                hist[23:16] <= mouse_data;
                hist[31:24] <= hist[23:16];
            end
            if (btn_up || btn_down || btn_center)
                value <= '0;
            else if (btn_left)
                value <= pc;
            else if (btn_right)
                value <= ir;
            else
                value <= hist;
        end
    end

endmodule

/* hw/priv_led_select.sv */
// RGB LED source select
// Shows the breathing PWM colour, or a short blink in the colour of
// the current privilege level once per blink period

`timescale 1ns/1ps

module priv_led_select (
    input  logic           CORE_CLK,
    input  logic           CORE_RST_X,
    input  logic [2:0]     pwm,
    input  logic           blink_on,
    input  logic           breathe,
    input  logic           init_done,
    input  soc_pkg::priv_e priv,
    output soc_pkg::rgb_t  rgb
);

    logic          blink_d;
    soc_pkg::rgb_t priv_rgb;

    always_comb begin
        case (priv)
            soc_pkg::PRIV_U: priv_rgb = soc_pkg::RGB_USER;
            soc_pkg::PRIV_S: priv_rgb = soc_pkg::RGB_SUPER;
            soc_pkg::PRIV_M: priv_rgb = soc_pkg::RGB_MACHINE;
            default:         priv_rgb = '0;  // Reserved level stays dark
        endcase
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            blink_d <= 1'b0;
            rgb     <= '0;
        end else begin
            blink_d <= blink_on;
            if (breathe)
                rgb <= pwm;
            else if (!init_done || !blink_d)
                rgb <= '0;
            else
                rgb <= priv_rgb;
        end
    end

endmodule

/* hw/rgb_phase_gen.sv */
// RGB phase generator
// Free-running PWM phase and blink counters shared by the channels
// and the privilege blink

`timescale 1ns/1ps

module rgb_phase_gen (
    input  logic                            CORE_CLK,
    input  logic                            CORE_RST_X,
    output logic [disp_pkg::PHASE_BITS-1:0] phase,
    output logic                            phase_zero,
    output logic                            blink_on
);

    logic [disp_pkg::BLINK_BITS-1:0] blink;

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            phase <= '0;
            blink <= '0;
        end else begin
            phase <= phase + 1'b1;
            blink <= blink + 1'b1;
        end
    end

    assign phase_zero = (phase == '0);  // Start of PWM period
    assign blink_on   = (blink == '0);

endmodule

/* hw/rgb_pwm_channel.sv */
// Breathing PWM channel
// Level ramps by STEP once per phase period; its top bit flips the
// compare so the duty cycle rises and then falls

`timescale 1ns/1ps

module rgb_pwm_channel #(
    parameter int START_LEVEL = 0,
    parameter int STEP        = 1
) (
    input  logic                            CORE_CLK,
    input  logic                            CORE_RST_X,
    input  logic [disp_pkg::PHASE_BITS-1:0] phase,
    input  logic                            phase_zero,
    output logic                            pwm
);

    localparam int PB = disp_pkg::PHASE_BITS;

    logic [PB:0] level;

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            level <= (PB + 1)'(START_LEVEL);
            pwm   <= 1'b0;
        end else begin
            if (phase_zero)
                level <= level + (PB + 1)'(STEP);
            // Falling half when the top bit is set
            pwm <= level[PB] ? (level[PB-1:0] < phase) : (level[PB-1:0] >= phase);
        end
    end

endmodule

/* hw/seg_drive.sv */
// Seven-segment output driver
// Decodes the scanned nibble, picks the glyph for the display mode and
// registers active-low segments together with the anode

`timescale 1ns/1ps

module seg_drive (
    input  logic                          CORE_CLK,
    input  logic                          CORE_RST_X,
    seg_scan_if.drive                     scan,
    output disp_pkg::glyph_t              seg,
    output logic [disp_pkg::N_DIGITS-1:0] an
);

    disp_pkg::glyph_t glyph;

    always_comb begin
        case (scan.mode)
            disp_pkg::DISP_INIT:  glyph = scan.init_g;
            disp_pkg::DISP_LOAD:  glyph = scan.load_g;
            disp_pkg::DISP_VALUE: glyph = disp_pkg::hex_glyph[scan.nibble];
            default:              glyph = '0;
        endcase
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            seg <= '1;  // Blank
            an  <= '1;
        end else if (scan.tick) begin
            seg <= ~glyph;
            an  <= scan.anode;
        end
    end

endmodule

/* hw/seg_scan.sv */
// Seven-segment digit scanner
// Steps through the eight digits every SCAN_DIV cycles, scrolls the
// load banner while loading and captures each digit's fields

`timescale 1ns/1ps

module seg_scan #(
    parameter int SCAN_DIV  = 16000,
    parameter int LOAD_STEP = 33554432
) (
    input  logic           CORE_CLK,
    input  logic           CORE_RST_X,
    input  soc_pkg::word_t value,
    input  logic           loading,
    input  logic           init_done,
    seg_scan_if.scan       scan
);

    localparam int SCAN_W  = $clog2(SCAN_DIV + 1);
    localparam int LOAD_W  = $clog2(LOAD_STEP + 1);
    localparam int DIGIT_W = $clog2(disp_pkg::N_DIGITS);

    logic [SCAN_W-1:0]  scan_cnt;
    logic [LOAD_W-1:0]  load_cnt;
    logic [3:0]         load_idx;   // Banner scroll position
    logic [DIGIT_W-1:0] digit;
    logic [3:0]         load_pos;

    // Digit d shows banner entry idx+7-d, wrapping at 16
    always_comb begin
        load_pos = load_idx + 4'd7 - 4'(digit);
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            scan_cnt    <= '0;
            load_cnt    <= '0;
            load_idx    <= '0;
            digit       <= '0;
            scan.tick   <= 1'b0;
            scan.anode  <= '1;
            scan.nibble <= '0;
            scan.init_g <= '0;
            scan.load_g <= '0;
            scan.mode   <= disp_pkg::DISP_INIT;
        end else begin
            if (loading) begin
                load_cnt <= (load_cnt == LOAD_W'(LOAD_STEP - 1)) ? '0 : load_cnt + 1'b1;
                if (load_cnt == '0)
                    load_idx <= load_idx + 4'd1;  // First loading cycle steps too
            end

            scan_cnt  <= (scan_cnt == SCAN_W'(SCAN_DIV - 1)) ? '0 : scan_cnt + 1'b1;
            scan.tick <= (scan_cnt == '0);
            if (scan_cnt == '0) begin
                digit       <= digit + 1'b1;  // Wraps after digit 7
                scan.anode  <= ~(disp_pkg::N_DIGITS'(1) << digit);
                scan.nibble <= value[{digit, 2'b00} +: 4];
                scan.init_g <= disp_pkg::init_glyph[digit];
                scan.load_g <= disp_pkg::load_glyph[load_pos];
                if (loading)
                    scan.mode <= disp_pkg::DISP_LOAD;
                else if (!init_done)
                    scan.mode <= disp_pkg::DISP_INIT;
                else
                    scan.mode <= disp_pkg::DISP_VALUE;
            end
        end
    end

endmodule

/* hw/seg_scan_if.sv */
// Digit scan bus
// One scanned digit, its banner glyphs and the display mode,
// passed from the scanner to the segment driver

`timescale 1ns/1ps

interface seg_scan_if;

    logic                         tick;    // New digit, one cycle
    logic [disp_pkg::N_DIGITS-1:0] anode;  // One-cold, active low
    logic [3:0]                   nibble;
    disp_pkg::glyph_t             init_g;
    disp_pkg::glyph_t             load_g;
    disp_pkg::disp_mode_e         mode;

    modport scan  (output tick, anode, nibble, init_g, load_g, mode);
    modport drive (input  tick, anode, nibble, init_g, load_g, mode);

endinterface

/* hw/soc_pkg.sv */
// SoC core-side types
// Data word, privilege levels and the RGB colour codes that the status
// panel shows for each privilege level of the core

package soc_pkg;

    typedef logic [31:0] word_t;  // PC, instruction word, display value

    // RISC-V privilege encoding, level 2 is reserved
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    // LED colour as {blue, green, red}
    typedef logic [2:0] rgb_t;

    localparam rgb_t RGB_USER    = 3'd1;
    localparam rgb_t RGB_SUPER   = 3'd2;
    localparam rgb_t RGB_MACHINE = 3'd4;

endpackage

/* hw/status_panel_top.sv */
// Status panel top level
// Seven-segment display, LED status word and RGB LED driven from
// the core status inputs of the SoC

`timescale 1ns/1ps

module status_panel_top #(
    parameter int HEARTBEAT_HALF = 32000000,
    parameter int SCAN_DIV       = 16000,
    parameter int LOAD_STEP      = 33554432
) (
    input  logic           CORE_CLK,
    input  logic           CORE_RST_X,
    input  logic           init_done,
    input  logic           init_start,
    input  logic           data_we,
    input  logic           busy,
    input  logic           kbd_we,
    input  logic [7:0]     kbd_data,
    input  logic           mouse_we,
    input  logic [7:0]     mouse_data,
    input  logic           btn_up,
    input  logic           btn_down,
    input  logic           btn_left,
    input  logic           btn_right,
    input  logic           btn_center,
    input  soc_pkg::word_t pc,
    input  soc_pkg::word_t ir,
    input  soc_pkg::priv_e priv,
    input  logic           breathe,
    output logic [15:0]    led,
    output logic [7:0]     seg,
    output logic [7:0]     an,
    output soc_pkg::rgb_t  rgb
);

    // Channel table, index 0 red, 1 green, 2 blue
    localparam int CH_START [3] = '{512, 64, 0};
    localparam int CH_STEP  [3] = '{5, 3, 2};

    logic                            loading;
    soc_pkg::word_t                  value;
    logic [disp_pkg::PHASE_BITS-1:0] phase;
    logic                            phase_zero;
    logic                            blink_on;
    logic [2:0]                      pwm;

    seg_scan_if scan_bus ();

    board_status_regs #(.HEARTBEAT_HALF(HEARTBEAT_HALF)) board_status_regs_i (
        .CORE_CLK(CORE_CLK), .CORE_RST_X(CORE_RST_X), .init_done(init_done),
        .init_start(init_start), .data_we(data_we), .busy(busy),
        .loading(loading), .led(led));

    panel_value_select panel_value_select_i (
        .CORE_CLK(CORE_CLK), .CORE_RST_X(CORE_RST_X),
        .kbd_we(kbd_we), .kbd_data(kbd_data), .mouse_we(mouse_we), .mouse_data(mouse_data),
        .btn_up(btn_up), .btn_down(btn_down), .btn_left(btn_left), .btn_right(btn_right),
        .btn_center(btn_center), .pc(pc), .ir(ir), .value(value));

    seg_scan #(.SCAN_DIV(SCAN_DIV), .LOAD_STEP(LOAD_STEP)) seg_scan_i (
        .CORE_CLK(CORE_CLK), .CORE_RST_X(CORE_RST_X), .value(value),
        .loading(loading), .init_done(init_done), .scan(scan_bus.scan));

    seg_drive seg_drive_i (
        .CORE_CLK(CORE_CLK), .CORE_RST_X(CORE_RST_X), .scan(scan_bus.drive),
        .seg(seg), .an(an));

    rgb_phase_gen rgb_phase_gen_i (
        .CORE_CLK(CORE_CLK), .CORE_RST_X(CORE_RST_X), .phase(phase),
        .phase_zero(phase_zero), .blink_on(blink_on));

    for (genvar i = 0; i < 3; i++) begin : g_ch
        rgb_pwm_channel #(.START_LEVEL(CH_START[i]), .STEP(CH_STEP[i])) rgb_pwm_channel_i (
            .CORE_CLK(CORE_CLK), .CORE_RST_X(CORE_RST_X), .phase(phase),
            .phase_zero(phase_zero), .pwm(pwm[i]));
    end

    priv_led_select priv_led_select_i (
        .CORE_CLK(CORE_CLK), .CORE_RST_X(CORE_RST_X), .pwm(pwm), .blink_on(blink_on),
        .breathe(breathe), .init_done(init_done), .priv(priv), .rgb(rgb));

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the status panel testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_status_panel
./obj_dir/Vtb_status_panel 2>&1 | tee "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi
echo "Simulation passed"

/* sim/tb_status_panel.sv */
// Status panel testbench
// Steps a stimulus table and checks the LED word, the digit scan and
// the RGB LED against cycle models of the panel

`timescale 1ns/1ps

module tb_status_panel;

    localparam int HB_HALF   = 20;
    localparam int SCAN_DIV  = 4;
    localparam int LOAD_STEP = 64;
    localparam int SEED      = 32'h5962_5113;
    localparam logic [12:0] CH_STEP [3] = '{13'd5, 13'd3, 13'd2};  // Red, green, blue

    typedef struct packed {
        logic           init_done;
        logic           init_start;
        logic           data_we;
        logic           busy;
        logic           kbd_we;
        logic           mouse_we;
        logic [7:0]     data;
        logic [4:0]     btn;        // up, down, left, right, center
        soc_pkg::priv_e priv;
        logic           breathe;
        int             hold;
        logic [15:0]    exp_led;    // Heartbeat bit left 0
        soc_pkg::word_t exp_value;
        soc_pkg::rgb_t  exp_rgb;    // Blink colour, 0 if dark
    } row_t;

    // What the scanner samples at one rising edge
    typedef struct packed {
        logic           loading;
        logic           init_done;
        logic [3:0]     idx;
        soc_pkg::word_t value;
    } snap_t;

    logic           CORE_CLK;
    logic           CORE_RST_X;
    logic           init_done, init_start, data_we, busy, kbd_we, mouse_we;
    logic [7:0]     kbd_data, mouse_data;
    logic           btn_up, btn_down, btn_left, btn_right, btn_center;
    soc_pkg::word_t pc, ir;
    soc_pkg::priv_e priv;
    logic           breathe;
    logic [15:0]    led;
    logic [7:0]     seg, an;
    soc_pkg::rgb_t  rgb;

    row_t           rows[$];
    soc_pkg::word_t hist_ref = '0;  // Byte history as the table grows
    int             hold_sum, cycle_cnt, cycle_limit, err_cnt;

    // Model state as after the last rising edge
    int             n_act = 0;      // Edges since reset release
    int             load_cycles = 0;
    logic           loading_m = 1'b0;
    logic [3:0]     idx_m = '0;
    soc_pkg::word_t value_m = '0;
    logic [11:0]    phase_m = '0;
    logic [3:0]     blink_m = '0;
    logic           blink_d_m = 1'b0;
    logic [12:0]    lvl_m [3] = '{13'd512, 13'd64, 13'd0};
    logic [2:0]     pwm_m = '0;
    soc_pkg::rgb_t  rgb_m = '0;
    snap_t          cap_cur = '0, cap_prev = '0;
    logic [7:0]     an_last = 8'hff;
    int             last_digit = 0, last_change = 0;

    status_panel_top #(
        .HEARTBEAT_HALF(HB_HALF), .SCAN_DIV(SCAN_DIV), .LOAD_STEP(LOAD_STEP)
    ) status_panel_top_i (.*);

    initial begin
        CORE_CLK = 1'b0;
        forever #4 CORE_CLK = ~CORE_CLK;
    end

    always @(posedge CORE_CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
            report_fail("Timeout, the stimulus table did not finish in time");
    end

    task automatic report_fail(input string why);
        err_cnt++;
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_led(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp)
            report_fail($sformatf("Fail led: got 0x%04h expected 0x%04h", got, exp));
    endtask

    task automatic check_glyph(input disp_pkg::glyph_t got, input disp_pkg::glyph_t exp);
        if (got !== exp)
            report_fail($sformatf("Fail seg: got 0x%02h expected 0x%02h", got, exp));
    endtask

    task automatic check_rgb(input soc_pkg::rgb_t got, input soc_pkg::rgb_t exp);
        if (got !== exp)
            report_fail($sformatf("Fail rgb: got 0x%0h expected 0x%0h", got, exp));
    endtask

    function automatic soc_pkg::word_t pick_value(input logic [4:0] btn,
                                                  input soc_pkg::word_t h);
        if (btn[4] || btn[3] || btn[0])
            return '0;
        else if (btn[2])
            return pc;
        else if (btn[1])
            return ir;
        else
            return h;
    endfunction

    function automatic soc_pkg::rgb_t priv_colour(input soc_pkg::priv_e p);
        case (p)
            soc_pkg::PRIV_U: return 3'd1;
            soc_pkg::PRIV_S: return 3'd2;
            soc_pkg::PRIV_M: return 3'd4;
            default:         return 3'd0;
        endcase
    endfunction

    // flags: init_done, init_start, data_we, busy, kbd_we, mouse_we
    task automatic add_row(input logic [5:0] flags, input logic [4:0] btn,
                           input soc_pkg::priv_e prv, input logic brth, input int hold);
        row_t r;
        {r.init_done, r.init_start, r.data_we, r.busy, r.kbd_we, r.mouse_we} = flags;
        r.data      = 8'($urandom);
        r.btn       = btn;
        r.priv      = prv;
        r.breathe   = brth;
        r.hold      = hold;
        r.exp_led   = {12'd0, r.busy, r.data_we, r.init_done, 1'b0};
        r.exp_value = pick_value(btn, hist_ref);  // Byte rows hold one cycle
        r.exp_rgb   = (brth || !r.init_done) ? 3'd0 : priv_colour(prv);
        if (r.kbd_we)
            hist_ref = {hist_ref[31:16], hist_ref[7:0], r.data};
        if (r.mouse_we)
            hist_ref = {hist_ref[23:16], r.data, hist_ref[15:0]};
        rows.push_back(r);
        hold_sum += hold;
    endtask

    task automatic build_table();
        add_row(6'b000000, 5'b00000, soc_pkg::PRIV_U, 1'b1, 3 * 4096);  // Breathing
        add_row(6'b001000, 5'b00000, soc_pkg::PRIV_M, 1'b0, 64);
        add_row(6'b000100, 5'b00000, soc_pkg::PRIV_S, 1'b0, 64);
        add_row(6'b010000, 5'b00000, soc_pkg::PRIV_U, 1'b0, 1);         // Start of load
        add_row(6'b000100, 5'b00000, soc_pkg::PRIV_U, 1'b0, 10 * LOAD_STEP);
        add_row(6'b100000, 5'b00000, soc_pkg::PRIV_U, 1'b0, 8);
        repeat (2) add_row(6'b100010, 5'b00000, soc_pkg::PRIV_U, 1'b0, 1);
        repeat (2) add_row(6'b100001, 5'b00000, soc_pkg::PRIV_U, 1'b0, 1);
        add_row(6'b100000, 5'b00000, soc_pkg::PRIV_U, 1'b0, 48);
        add_row(6'b100000, 5'b00100, soc_pkg::PRIV_U, 1'b0, 48);
        add_row(6'b100000, 5'b00010, soc_pkg::PRIV_U, 1'b0, 48);
        add_row(6'b100000, 5'b10000, soc_pkg::PRIV_U, 1'b0, 48);
        add_row(6'b100000, 5'b01000, soc_pkg::PRIV_U, 1'b0, 48);
        add_row(6'b100000, 5'b00001, soc_pkg::PRIV_U, 1'b0, 48);
        add_row(6'b100000, 5'b00110, soc_pkg::PRIV_U, 1'b0, 48);  // Left wins over right
        add_row(6'b100000, 5'b10100, soc_pkg::PRIV_U, 1'b0, 48);
        add_row(6'b100000, 5'b00000, soc_pkg::PRIV_U, 1'b0, 64);  // Privilege blink
        add_row(6'b100000, 5'b00000, soc_pkg::PRIV_S, 1'b0, 64);
        add_row(6'b100000, 5'b00000, soc_pkg::PRIV_M, 1'b0, 64);
    endtask

    // Advance the models by one rising edge, then check at the falling edge
    task automatic step_check(input row_t r);
        logic [2:0]       pwm_pre;
        int               c;
        int               d;
        disp_pkg::glyph_t g;
        pwm_pre  = pwm_m;
        cap_prev = cap_cur;
        cap_cur  = '{loading_m, r.init_done, idx_m, value_m};
        n_act++;
        if (loading_m) begin
            if (load_cycles % LOAD_STEP == 0)
                idx_m = idx_m + 4'd1;
            load_cycles++;
        end
        if (!loading_m && r.init_start && !r.init_done)
            loading_m = 1'b1;
        else if (r.init_done)
            loading_m = 1'b0;
        value_m = r.exp_value;
        for (c = 0; c < 3; c++) begin
            pwm_m[c] = lvl_m[c][12] ? (lvl_m[c][11:0] < phase_m) : (lvl_m[c][11:0] >= phase_m);
            if (phase_m == 12'd0)
                lvl_m[c] = lvl_m[c] + CH_STEP[c];
        end
        rgb_m     = r.breathe ? pwm_pre : (blink_d_m ? r.exp_rgb : 3'd0);
        blink_d_m = (blink_m == 4'd0);
        phase_m   = phase_m + 12'd1;
        blink_m   = blink_m + 4'd1;
        @(negedge CORE_CLK);
        check_led(led, r.exp_led | 16'((n_act / HB_HALF) % 2));
        check_rgb(rgb, rgb_m);
        if (an !== an_last) begin
            d = 0;
            while (d < 8 && an !== ~(8'd1 << d))
                d++;
            if (d == 8)
                report_fail($sformatf("Anode pattern 0x%02h is not one-cold", an));
            if (last_change > 0 && (d != (last_digit + 1) % 8 || n_act - last_change != SCAN_DIV))
                report_fail("Digit scan is out of order or off its timing");
            if (cap_prev.loading)
                g = disp_pkg::load_glyph[(int'(cap_prev.idx) + 23 - d) % 16];
            else if (!cap_prev.init_done)
                g = disp_pkg::init_glyph[d];
            else
                g = disp_pkg::hex_glyph[cap_prev.value[4 * d +: 4]];
            check_glyph(seg, ~g);
            an_last     = an;
            last_digit  = d;
            last_change = n_act;
        end else if (n_act - last_change > SCAN_DIV) begin
            report_fail("Anode did not move on to the next digit in time");
        end
    endtask

    initial begin
        row_t r;
        int   seed_ret;
        int   nz;
        seed_ret = $urandom(SEED);
        {init_done, init_start, data_we, busy, kbd_we, mouse_we} = '0;
        {btn_up, btn_down, btn_left, btn_right, btn_center} = '0;
        kbd_data   = '0;
        mouse_data = '0;
        priv       = soc_pkg::PRIV_U;
        breathe    = 1'b1;
        CORE_RST_X = 1'b0;
        pc = $urandom;
        ir = $urandom;
        build_table();
        cycle_limit = 2 * hold_sum;
        repeat (10) @(negedge CORE_CLK);
        check_glyph(seg, 8'hff);
        check_led(led, 16'h0000);
        check_rgb(rgb, 3'd0);
        if (an !== 8'hff)
            report_fail($sformatf("Fail an: got 0x%02h expected 0xff", an));
        CORE_RST_X = 1'b1;
        foreach (rows[i]) begin
            r = rows[i];
            {init_done, init_start, data_we, busy, kbd_we, mouse_we} =
                {r.init_done, r.init_start, r.data_we, r.busy, r.kbd_we, r.mouse_we};
            kbd_data   = r.kbd_we ? r.data : ~r.data;  // Idle bus carries another byte
            mouse_data = r.mouse_we ? r.data : ~r.data;
            {btn_up, btn_down, btn_left, btn_right, btn_center} = r.btn;
            priv    = r.priv;
            breathe = r.breathe;
            nz      = 0;
            repeat (r.hold) begin
                step_check(r);
                if (rgb != 3'd0)
                    nz++;
            end
            // One lit cycle per blink period of 16
            if (!r.breathe && r.hold % 16 == 0 && nz != (r.exp_rgb != 0 ? r.hold / 16 : 0))
                report_fail($sformatf("RGB lit in %0d of %0d cycles in row %0d", nz, r.hold, i));
        end
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
